// File: source/armIsaPkg.sv
`default_nettype none

package armIsaPkg;

    localparam int dataWidth  = 32;
    localparam int regCount   = 16;
    localparam int shamtWidth = 5;
    localparam int rotWidth   = 4;
    localparam int imm8Width  = 8;

    // Field positions in a data-processing word
    localparam int condPos     = 28;
    localparam int classPos    = 26;
    localparam int immFlagPos  = 25;
    localparam int opcodePos   = 21;
    localparam int sBitPos     = 20;
    localparam int rnPos       = 16;
    localparam int rdPos       = 12;
    localparam int rotPos      = 8;
    localparam int shamtPos    = 7;
    localparam int shTypePos   = 5;
    localparam int regShiftPos = 4;
    localparam int rmPos       = 0;
    localparam int imm8Pos     = 0;

    typedef logic [$clog2(regCount)-1:0] regIndex;
    typedef logic [dataWidth-1:0]        dataWord;
    typedef logic [31:0]                 instrWord;

    typedef enum logic [3:0] {
        opAnd, opEor, opSub, opRsb, opAdd, opAdc, opSbc, opRsc,
        opTst, opTeq, opCmp, opCmn, opOrr, opMov, opBic, opMvn
    } dpOpcode;

    // condNv is the 1111 encoding, never taken here
    typedef enum logic [3:0] {
        condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
        condHi, condLs, condGe, condLt, condGt, condLe, condAl, condNv
    } condCode;

    typedef enum logic [1:0] {shLsl, shLsr, shAsr, shRor} shiftType;

endpackage

`default_nettype wire

// File: source/corePkg.sv
`default_nettype none

package corePkg;

    import armIsaPkg::*;

    localparam int retireDepth    = 4;
    localparam int retireIdxWidth = $clog2(retireDepth);

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } archFlags;

    typedef struct packed {
        logic                  supported;
        condCode               cond;
        dpOpcode               opcode;
        logic                  setFlags;
        regIndex               rn;
        regIndex               rd;
        regIndex               rm;
        logic                  isImm;
        dataWord               imm;
        logic                  immRotated;
        logic [shamtWidth-1:0] shamt;
        shiftType              shType;
    } decodedOp;

    typedef struct packed {
        logic     executed;
        logic     writesReg;
        regIndex  rd;
        dataWord  value;
        archFlags flags;
    } retireRecord;

endpackage

`default_nettype wire

// File: source/instrIntake.sv
`timescale 1ns/1ps
`default_nettype none

module instrIntake
    import armIsaPkg::*;
(
    input  wire           CLK,
    input  wire           rst,
    input  wire           instrReq,
    output logic          instrAck,
    input  wire instrWord instr,
    output logic          slotValid,
    output instrWord      slotInstr,
    input  wire           take
);

    typedef enum logic [1:0] {idle, holding, waitRelease} intakeState;

    intakeState state;
    logic       capture;

    // Word is only taken in once the slot has drained
    assign capture = (state != waitRelease) && instrReq && !slotValid;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= idle;
            instrAck  <= 1'b0;
            slotValid <= 1'b0;
        end else begin
            if (take) begin
                slotValid <= 1'b0;
            end
            case (state)
                idle, holding: begin
                    if (capture) begin
                        slotValid <= 1'b1;
                        instrAck  <= 1'b1;
                        state     <= waitRelease;
                    end else if (instrReq) begin
                        state <= holding;
                    end
                end
                waitRelease: begin
                    if (!instrReq) begin
                        instrAck <= 1'b0;
                        state    <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            slotInstr <= instr;
        end
    end

endmodule

`default_nettype wire

// File: source/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import armIsaPkg::*;
    import corePkg::*;
(
    input  wire           CLK,
    input  wire           rst,
    input  wire           slotValid,
    input  wire instrWord slotInstr,
    output logic          take,
    output logic          decodedValid,
    output decodedOp      decoded,
    input  wire           accept
);

    decodedOp               nextOp;
    dataWord                immBase;
    logic [rotWidth:0]      rotAmount;
    logic [2*dataWidth-1:0] immPair;

    //////////////////////////////////////////////////
    // Field extraction

    // Rotate right by twice the 4-bit field
    assign rotAmount = {slotInstr[rotPos +: rotWidth], 1'b0};
    assign immBase   = dataWord'(slotInstr[imm8Pos +: imm8Width]);
    assign immPair   = {immBase, immBase} >> rotAmount;

    always_comb begin
        nextOp.isImm      = slotInstr[immFlagPos];
        // Register forms with bit 4 set shift by a register, not kept
        nextOp.supported  = (slotInstr[classPos +: 2] == 2'b00)
                            && (slotInstr[immFlagPos] || !slotInstr[regShiftPos]);
        nextOp.cond       = condCode'(slotInstr[condPos +: $bits(condCode)]);
        nextOp.opcode     = dpOpcode'(slotInstr[opcodePos +: $bits(dpOpcode)]);
        nextOp.setFlags   = slotInstr[sBitPos];
        nextOp.rn         = slotInstr[rnPos +: $bits(regIndex)];
        nextOp.rd         = slotInstr[rdPos +: $bits(regIndex)];
        nextOp.rm         = slotInstr[rmPos +: $bits(regIndex)];
        nextOp.imm        = immPair[dataWidth-1:0];
        nextOp.immRotated = (rotAmount != '0);
        nextOp.shamt      = slotInstr[shamtPos +: shamtWidth];
        nextOp.shType     = shiftType'(slotInstr[shTypePos +: $bits(shiftType)]);
    end

    //////////////////////////////////////////////////
    // Stage register

    // Slot drains when the register is empty or moving on
    assign take = slotValid && (!decodedValid || accept);

    always_ff @(posedge CLK) begin
        if (rst) begin
            decodedValid <= 1'b0;
        end else if (take) begin
            decodedValid <= 1'b1;
        end else if (accept) begin
            decodedValid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            decoded <= nextOp;
        end
    end

endmodule

`default_nettype wire

// File: source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
    import armIsaPkg::*;
(
    input  wire          CLK,
    input  wire          rst,
    input  wire regIndex rnAddr,
    input  wire regIndex rmAddr,
    output dataWord      rnData,
    output dataWord      rmData,
    input  wire          writeEn,
    input  wire regIndex writeAddr,
    input  wire dataWord writeData
);

    dataWord regs [regCount];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Reads see the value from the last edge
    assign rnData = regs[rnAddr];
    assign rmData = regs[rmAddr];

endmodule

`default_nettype wire

// File: source/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import armIsaPkg::*;
    import corePkg::*;
(
    input  wire           CLK,
    input  wire           rst,
    input  wire           decodedValid,
    input  wire decodedOp decoded,
    output logic          accept,
    output regIndex       rnAddr,
    output regIndex       rmAddr,
    input  wire dataWord  rnData,
    input  wire dataWord  rmData,
    output logic          writeEn,
    output regIndex       writeAddr,
    output dataWord       writeData,
    output logic          push,
    output retireRecord   pushRecord,
    input  wire           full
);

    archFlags               flags;
    archFlags               aluFlags;
    archFlags               nextFlags;
    dataWord                shOut;
    logic                   shCarry;
    logic [2*dataWidth-1:0] rorPair;
    logic signed [dataWidth:0] asrWide;
    dataWord                addA;
    dataWord                addB;
    logic                   addCin;
    logic                   arith;
    logic [dataWidth:0]     sum;
    dataWord                result;
    logic                   condPass;
    logic                   executed;
    logic                   writesReg;
    logic                   fire;

    assign rnAddr = decoded.rn;
    assign rmAddr = decoded.rm;

    //////////////////////////////////////////////////
    // Barrel shifter

    assign rorPair = {rmData, rmData} >> decoded.shamt;
    assign asrWide = $signed({rmData, 1'b0}) >>> decoded.shamt;

    always_comb begin
        shOut   = rmData;
        shCarry = flags.c;
        if (decoded.isImm) begin
            shOut   = decoded.imm;
            shCarry = decoded.immRotated ? decoded.imm[dataWidth-1] : flags.c;
        end else begin
            case (decoded.shType)
                shLsl: begin
                    if (decoded.shamt != '0) begin
                        {shCarry, shOut} = {1'b0, rmData} << decoded.shamt;
                    end
                end
                shLsr: begin
                    // Amount 0 encodes a shift by 32
                    if (decoded.shamt == '0) begin
                        shOut   = '0;
                        shCarry = rmData[dataWidth-1];
                    end else begin
                        {shOut, shCarry} = {rmData, 1'b0} >> decoded.shamt;
                    end
                end
                shAsr: begin
                    if (decoded.shamt == '0) begin
                        shOut   = {dataWidth{rmData[dataWidth-1]}};
                        shCarry = rmData[dataWidth-1];
                    end else begin
                        {shOut, shCarry} = asrWide;
                    end
                end
                shRor: begin
                    // RRX when the amount is 0
                    if (decoded.shamt == '0) begin
                        shOut   = {flags.c, rmData[dataWidth-1:1]};
                        shCarry = rmData[0];
                    end else begin
                        shOut   = rorPair[dataWidth-1:0];
                        shCarry = rorPair[dataWidth-1];
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // ALU

    // Subtractions add the inverted operand, so C ends up as no borrow
    always_comb begin
        addA   = rnData;
        addB   = shOut;
        addCin = 1'b0;
        arith  = 1'b1;
        case (decoded.opcode)
            opAdd, opCmn: arith = 1'b1;
            opAdc: addCin = flags.c;
            opSub, opCmp: begin
                addB   = ~shOut;
                addCin = 1'b1;
            end
            opSbc: begin
                addB   = ~shOut;
                addCin = flags.c;
            end
            opRsb: begin
                addA   = shOut;
                addB   = ~rnData;
                addCin = 1'b1;
            end
            opRsc: begin
                addA   = shOut;
                addB   = ~rnData;
                addCin = flags.c;
            end
            default: arith = 1'b0;
        endcase
    end

    assign sum = {1'b0, addA} + {1'b0, addB} + addCin;

    always_comb begin
        case (decoded.opcode)
            opAnd, opTst: result = rnData & shOut;
            opEor, opTeq: result = rnData ^ shOut;
            opOrr:        result = rnData | shOut;
            opMov:        result = shOut;
            opBic:        result = rnData & ~shOut;
            opMvn:        result = ~shOut;
            default:      result = sum[dataWidth-1:0];
        endcase
    end

    always_comb begin
        aluFlags.n = result[dataWidth-1];
        aluFlags.z = (result == '0);
        aluFlags.c = arith ? sum[dataWidth] : shCarry;
        aluFlags.v = arith ? (addA[dataWidth-1] == addB[dataWidth-1])
                             && (sum[dataWidth-1] != addA[dataWidth-1])
                           : flags.v;
    end

    //////////////////////////////////////////////////
    // Condition check and flags

    always_comb begin
        case (decoded.cond)
            condEq:  condPass = flags.z;
            condNe:  condPass = !flags.z;
            condCs:  condPass = flags.c;
            condCc:  condPass = !flags.c;
            condMi:  condPass = flags.n;
            condPl:  condPass = !flags.n;
            condVs:  condPass = flags.v;
            condVc:  condPass = !flags.v;
            condHi:  condPass = flags.c && !flags.z;
            condLs:  condPass = !flags.c || flags.z;
            condGe:  condPass = (flags.n == flags.v);
            condLt:  condPass = (flags.n != flags.v);
            condGt:  condPass = !flags.z && (flags.n == flags.v);
            condLe:  condPass = flags.z || (flags.n != flags.v);
            condAl:  condPass = 1'b1;
            default: condPass = 1'b0;
        endcase
    end

    assign accept    = !full;
    assign fire      = decodedValid && accept;
    assign executed  = decoded.supported && condPass;
    assign writesReg = executed && !(decoded.opcode inside {opTst, opTeq, opCmp, opCmn});
    assign nextFlags = (executed && decoded.setFlags) ? aluFlags : flags;

    always_ff @(posedge CLK) begin
        if (rst) begin
            flags <= '0;
        end else if (fire) begin
            flags <= nextFlags;
        end
    end

    // Write and push both land at the end of this cycle
    assign writeEn   = fire && writesReg;
    assign writeAddr = decoded.rd;
    assign writeData = result;
    assign push      = fire;

    always_comb begin
        pushRecord.executed  = executed;
        pushRecord.writesReg = writesReg;
        pushRecord.rd        = decoded.rd;
        pushRecord.value     = executed ? result : '0;
        pushRecord.flags     = nextFlags;
    end

endmodule

`default_nettype wire

// File: source/retireQueue.sv
`timescale 1ns/1ps
`default_nettype none

module retireQueue
    import corePkg::*;
(
    input  wire              CLK,
    input  wire              rst,
    input  wire              push,
    input  wire retireRecord pushRecord,
    output logic             full,
    output logic             retireReq,
    input  wire              retireAck,
    output retireRecord      retire
);

    typedef enum logic [1:0] {idle, requesting, waitRelease} sendState;

    sendState                  state;
    retireRecord               entries [retireDepth];
    logic [retireIdxWidth-1:0] headPtr;
    logic [retireIdxWidth-1:0] tailPtr;
    logic [retireIdxWidth:0]   count;
    logic                      pop;

    assign full   = (count == (retireIdxWidth + 1)'(retireDepth));
    assign retire = entries[headPtr];

    // Head leaves once the receiver has released its ack
    assign pop = (state == waitRelease) && !retireAck;

    always_ff @(posedge CLK) begin
        if (push) begin
            entries[tailPtr] <= pushRecord;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= idle;
            retireReq <= 1'b0;
            headPtr   <= '0;
            tailPtr   <= '0;
            count     <= '0;
        end else begin
            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            case (state)
                idle: begin
                    if (count != '0) begin
                        retireReq <= 1'b1;
                        state     <= requesting;
                    end
                end
                requesting: begin
                    if (retireAck) begin
                        retireReq <= 1'b0;
                        state     <= waitRelease;
                    end
                end
                waitRelease: begin
                    if (!retireAck) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/armCore.sv
`timescale 1ns/1ps
`default_nettype none

module armCore
    import armIsaPkg::*;
    import corePkg::*;
(
    input  wire           CLK,
    input  wire           rst,
    input  wire           instrReq,
    output logic          instrAck,
    input  wire instrWord instr,
    output logic          retireReq,
    input  wire           retireAck,
    output retireRecord   retire
);

    logic        slotValid;
    instrWord    slotInstr;
    logic        take;
    logic        decodedValid;
    decodedOp    decoded;
    logic        accept;
    regIndex     rnAddr;
    regIndex     rmAddr;
    dataWord     rnData;
    dataWord     rmData;
    logic        writeEn;
    regIndex     writeAddr;
    dataWord     writeData;
    logic        push;
    retireRecord pushRecord;
    logic        full;

    //////////////////////////////////////////////////
    // Input side

    instrIntake instrIntake (
        .CLK        (CLK        ),
        .rst        (rst        ),
        .instrReq   (instrReq   ),
        .instrAck   (instrAck   ),
        .instr      (instr      ),
        .slotValid  (slotValid  ),
        .slotInstr  (slotInstr  ),
        .take       (take       ));

    //////////////////////////////////////////////////
    // Processing

    decodeStage decodeStage (
        .CLK          (CLK          ),
        .rst          (rst          ),
        .slotValid    (slotValid    ),
        .slotInstr    (slotInstr    ),
        .take         (take         ),
        .decodedValid (decodedValid ),
        .decoded      (decoded      ),
        .accept       (accept       ));

    registerFile registerFile (
        .CLK        (CLK        ),
        .rst        (rst        ),
        .rnAddr     (rnAddr     ),
        .rmAddr     (rmAddr     ),
        .rnData     (rnData     ),
        .rmData     (rmData     ),
        .writeEn    (writeEn    ),
        .writeAddr  (writeAddr  ),
        .writeData  (writeData  ));

    executeStage executeStage (
        .CLK          (CLK          ),
        .rst          (rst          ),
        .decodedValid (decodedValid ),
        .decoded      (decoded      ),
        .accept       (accept       ),
        .rnAddr       (rnAddr       ),
        .rmAddr       (rmAddr       ),
        .rnData       (rnData       ),
        .rmData       (rmData       ),
        .writeEn      (writeEn      ),
        .writeAddr    (writeAddr    ),
        .writeData    (writeData    ),
        .push         (push         ),
        .pushRecord   (pushRecord   ),
        .full         (full         ));

    //////////////////////////////////////////////////
    // Output side

    retireQueue retireQueue (
        .CLK        (CLK        ),
        .rst        (rst        ),
        .push       (push       ),
        .pushRecord (pushRecord ),
        .full       (full       ),
        .retireReq  (retireReq  ),
        .retireAck  (retireAck  ),
        .retire     (retire     ));

endmodule

`default_nettype wire

// File: tests/armCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module armCoreTb
    import armIsaPkg::*;
    import corePkg::*;
();

    localparam int clockPeriod    = 8;
    localparam int resetCycles    = 8;
    localparam int cyclesPerInstr = 40;
    localparam int randomCount    = 200;
    localparam int drainCycles    = 20;

    logic        CLK;
    logic        rst;
    logic        instrReq;
    logic        instrAck;
    instrWord    instr;
    logic        retireReq;
    logic        retireAck;
    retireRecord retire;

    int          seed;
    int          retiredCount;
    logic        programReady;
    dataWord     modelRegs [regCount];
    archFlags    modelFlags;
    instrWord    stimulus [$];
    retireRecord expectedQ [$];

    always #(clockPeriod / 2) CLK = ~CLK;

    armCore i_armCore (
        .CLK       (CLK       ),
        .rst       (rst       ),
        .instrReq  (instrReq  ),
        .instrAck  (instrAck  ),
        .instr     (instr     ),
        .retireReq (retireReq ),
        .retireAck (retireAck ),
        .retire    (retire    ));

    task automatic failRun(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkRecord(retireRecord expectedRec, retireRecord actualRec);
        if (actualRec !== expectedRec) begin
            failRun($sformatf("error: retire expected %h actual %h",
                              expectedRec, actualRec));
        end
    endtask

    task automatic checkLevel(string name, logic expectedLevel, logic actualLevel);
        if (actualLevel !== expectedLevel) begin
            failRun($sformatf("error: %s expected %h actual %h",
                              name, expectedLevel, actualLevel));
        end
    endtask

    function automatic instrWord dpImm(condCode cond, dpOpcode op, logic s, regIndex rn,
                                       regIndex rd, logic [3:0] rot, logic [7:0] imm8);
        return {cond, 2'b00, 1'b1, op, s, rn, rd, rot, imm8};
    endfunction

    function automatic instrWord dpReg(condCode cond, dpOpcode op, logic s, regIndex rn,
                                       regIndex rd, logic [4:0] shamt, shiftType sh,
                                       regIndex rm);
        return {cond, 2'b00, 1'b0, op, s, rn, rd, shamt, sh, 1'b0, rm};
    endfunction

    //////////////////////////////////////////////////
    // Reference model

    function automatic retireRecord modelWord(instrWord w);
        retireRecord rec;
        dpOpcode     op;
        logic        isImm;
        logic        supported;
        logic        passed;
        logic        shCarry;
        logic        isArith;
        logic        isSub;
        logic        cin;
        logic        carryOut;
        logic        overflow;
        logic [4:0]  amount;
        dataWord     a;
        dataWord     b;
        dataWord     x;
        dataWord     y;
        dataWord     rmVal;
        dataWord     res;
        logic [32:0] wide;
        archFlags    f;

        f         = modelFlags;
        op        = dpOpcode'(w[24:21]);
        isImm     = w[25];
        supported = (w[27:26] == 2'b00) && (isImm || !w[4]);
        a         = modelRegs[w[19:16]];
        rmVal     = modelRegs[w[3:0]];
        amount    = w[11:7];
        shCarry   = f.c;

        if (isImm) begin
            b = dataWord'(w[7:0]);
            if (w[11:8] != 4'd0) begin
                b       = (b >> (2 * w[11:8])) | (b << (32 - 2 * w[11:8]));
                shCarry = b[31];
            end
        end else begin
            b = rmVal;
            case (w[6:5])
                2'd0: begin
                    if (amount != 5'd0) begin
                        b       = rmVal << amount;
                        shCarry = rmVal[32 - amount];
                    end
                end
                2'd1: begin
                    // Zero amount stands for 32
                    b       = (amount == 5'd0) ? 32'd0 : rmVal >> amount;
                    shCarry = (amount == 5'd0) ? rmVal[31] : rmVal[amount - 1];
                end
                2'd2: begin
                    if (amount == 5'd0) begin
                        b       = {32{rmVal[31]}};
                        shCarry = rmVal[31];
                    end else begin
                        b       = $signed(rmVal) >>> amount;
                        shCarry = rmVal[amount - 1];
                    end
                end
                default: begin
                    if (amount == 5'd0) begin
                        b       = {f.c, rmVal[31:1]};
                        shCarry = rmVal[0];
                    end else begin
                        b       = (rmVal >> amount) | (rmVal << (32 - amount));
                        shCarry = rmVal[amount - 1];
                    end
                end
            endcase
        end

        case (condCode'(w[31:28]))
            condEq:  passed = f.z;
            condNe:  passed = !f.z;
            condCs:  passed = f.c;
            condCc:  passed = !f.c;
            condMi:  passed = f.n;
            condPl:  passed = !f.n;
            condVs:  passed = f.v;
            condVc:  passed = !f.v;
            condHi:  passed = f.c && !f.z;
            condLs:  passed = !f.c || f.z;
            condGe:  passed = (f.n == f.v);
            condLt:  passed = (f.n != f.v);
            condGt:  passed = !f.z && (f.n == f.v);
            condLe:  passed = f.z || (f.n != f.v);
            condAl:  passed = 1'b1;
            default: passed = 1'b0;
        endcase

        isArith = 1'b1;
        isSub   = 1'b0;
        x       = a;
        y       = b;
        cin     = 1'b0;
        case (op)
            opAdd, opCmn: cin = 1'b0;
            opAdc: cin = f.c;
            opSub, opCmp: isSub = 1'b1;
            opSbc: begin
                isSub = 1'b1;
                cin   = !f.c;
            end
            opRsb: begin
                isSub = 1'b1;
                x     = b;
                y     = a;
            end
            opRsc: begin
                isSub = 1'b1;
                x     = b;
                y     = a;
                cin   = !f.c;
            end
            default: isArith = 1'b0;
        endcase

        // Here cin is a borrow for the subtractions
        if (isSub) begin
            wide     = {1'b0, x} - {1'b0, y} - cin;
            carryOut = !wide[32];
            overflow = (x[31] != y[31]) && (wide[31] != x[31]);
        end else begin
            wide     = {1'b0, x} + {1'b0, y} + cin;
            carryOut = wide[32];
            overflow = (x[31] == y[31]) && (wide[31] != x[31]);
        end

        case (op)
            opAnd, opTst: res = a & b;
            opEor, opTeq: res = a ^ b;
            opOrr:        res = a | b;
            opMov:        res = b;
            opBic:        res = a & ~b;
            opMvn:        res = ~b;
            default:      res = wide[31:0];
        endcase

        rec.executed  = supported && passed;
        rec.writesReg = rec.executed && (op < opTst || op > opCmn);
        rec.rd        = w[15:12];
        rec.value     = rec.executed ? res : 32'd0;
        if (rec.executed && w[20]) begin
            modelFlags.n = res[31];
            modelFlags.z = (res == 32'd0);
            modelFlags.c = isArith ? carryOut : shCarry;
            modelFlags.v = isArith ? overflow : f.v;
        end
        if (rec.writesReg) begin
            modelRegs[w[15:12]] = res;
        end
        rec.flags = modelFlags;
        return rec;
    endfunction

    task automatic queueWord(instrWord w);
        stimulus.push_back(w);
        expectedQ.push_back(modelWord(w));
    endtask

    //////////////////////////////////////////////////
    // Instruction stream

    task automatic buildProgram();
        instrWord w;

        for (int i = 0; i < regCount; i++) begin
            modelRegs[i] = '0;
        end
        modelFlags = '0;

        // MOV immediates with a range of rotations
        queueWord(dpImm(condAl, opMov, 1'b0, 4'd0, 4'd1, 4'd0, 8'hFF));
        queueWord(dpImm(condAl, opMov, 1'b0, 4'd0, 4'd2, 4'd4, 8'hAB));
        queueWord(dpImm(condAl, opMov, 1'b0, 4'd0, 4'd3, 4'd1, 8'h03));
        queueWord(dpImm(condAl, opMov, 1'b0, 4'd0, 4'd4, 4'd15, 8'h81));
        // r5 gets 0x7FFFFFFF, then carry and overflow edges
        queueWord(dpImm(condAl, opMvn, 1'b0, 4'd0, 4'd5, 4'd1, 8'h02));
        queueWord(dpImm(condAl, opAdd, 1'b1, 4'd5, 4'd6, 4'd0, 8'h01));
        queueWord(dpReg(condAl, opAdd, 1'b1, 4'd6, 4'd7, 5'd0, shLsl, 4'd6));
        queueWord(dpImm(condAl, opAdc, 1'b0, 4'd1, 4'd8, 4'd0, 8'h10));
        queueWord(dpReg(condAl, opSub, 1'b1, 4'd1, 4'd9, 5'd0, shLsl, 4'd2));
        queueWord(dpImm(condAl, opRsb, 1'b1, 4'd3, 4'd10, 4'd0, 8'h01));
        queueWord(dpReg(condAl, opSbc, 1'b1, 4'd2, 4'd11, 5'd0, shLsl, 4'd1));
        queueWord(dpImm(condAl, opRsc, 1'b1, 4'd1, 4'd12, 4'd0, 8'h05));
        queueWord(dpImm(condAl, opMvn, 1'b0, 4'd0, 4'd13, 4'd0, 8'h00));
        queueWord(dpImm(condAl, opAdd, 1'b1, 4'd13, 4'd14, 4'd0, 8'h01));
        queueWord(dpReg(condAl, opSub, 1'b1, 4'd5, 4'd0, 5'd0, shLsl, 4'd5));
        // Shifted register operands
        queueWord(dpReg(condAl, opMov, 1'b0, 4'd0, 4'd1, 5'd4, shLsl, 4'd3));
        queueWord(dpReg(condAl, opMov, 1'b1, 4'd0, 4'd2, 5'd0, shLsr, 4'd13));
        queueWord(dpReg(condAl, opMov, 1'b1, 4'd0, 4'd3, 5'd4, shAsr, 4'd6));
        queueWord(dpReg(condAl, opMov, 1'b1, 4'd0, 4'd4, 5'd8, shRor, 4'd8));
        queueWord(dpReg(condAl, opMov, 1'b1, 4'd0, 4'd5, 5'd0, shRor, 4'd9));
        queueWord(dpReg(condAl, opAnd, 1'b1, 4'd13, 4'd6, 5'd1, shLsr, 4'd3));
        queueWord(dpReg(condAl, opAdd, 1'b0, 4'd1, 4'd7, 5'd31, shLsl, 4'd13));
        queueWord(dpReg(condAl, opEor, 1'b1, 4'd13, 4'd8, 5'd0, shAsr, 4'd3));
        // Z set, so the NE move is skipped and r2 copies the old r1
        queueWord(dpReg(condAl, opCmp, 1'b1, 4'd0, 4'd0, 5'd0, shLsl, 4'd0));
        queueWord(dpImm(condNe, opMov, 1'b0, 4'd0, 4'd1, 4'd0, 8'h55));
        queueWord(dpReg(condAl, opMov, 1'b0, 4'd0, 4'd2, 5'd0, shLsl, 4'd1));
        queueWord(dpImm(condEq, opMov, 1'b0, 4'd0, 4'd3, 4'd0, 8'h66));
        queueWord(dpImm(condAl, opTst, 1'b1, 4'd13, 4'd0, 4'd0, 8'h01));
        queueWord(dpReg(condAl, opTeq, 1'b1, 4'd2, 4'd0, 5'd0, shLsl, 4'd2));
        queueWord(dpImm(condAl, opCmn, 1'b1, 4'd13, 4'd0, 4'd0, 8'h01));
        queueWord(dpImm(condAl, opCmp, 1'b1, 4'd3, 4'd0, 4'd0, 8'h70));
        queueWord(dpImm(condGt, opMov, 1'b0, 4'd0, 4'd4, 4'd0, 8'h77));
        // Load, branch, multiply, register shift and the never condition
        queueWord(32'hE5912000);
        queueWord(32'hEA000000);
        queueWord(32'hE0010392);
        queueWord(32'hE1A01312);
        queueWord(32'hF3A01001);

        for (int i = 0; i < randomCount; i++) begin
            w        = $random(seed);
            w[27:26] = 2'b00;
            if (!w[25]) begin
                w[4] = 1'b0;
            end
            queueWord(w);
        end
    endtask

    task automatic sendWord(instrWord w);
        instrReq <= 1'b1;
        instr    <= w;
        @(posedge CLK);
        while (!instrAck) @(posedge CLK);
        instrReq <= 1'b0;
        @(posedge CLK);
        while (instrAck) @(posedge CLK);
    endtask

    //////////////////////////////////////////////////
    // Processes

    initial begin : mainFlow
        CLK          = 1'b0;
        rst          = 1'b1;
        instrReq     = 1'b0;
        instr        = '0;
        retireAck    = 1'b0;
        seed         = 28;
        retiredCount = 0;
        programReady = 1'b0;
        buildProgram();
        programReady = 1'b1;

        repeat (resetCycles) @(posedge CLK);
        rst <= 1'b0;
        @(posedge CLK);
        checkLevel("instrAck", 1'b0, instrAck);
        checkLevel("retireReq", 1'b0, retireReq);

        foreach (stimulus[i]) begin
            sendWord(stimulus[i]);
        end
        while (expectedQ.size() != 0) @(posedge CLK);
        // Room for any stray record to show up
        repeat (drainCycles) @(posedge CLK);
        if (retiredCount != stimulus.size()) begin
            failRun("number of retired records differs from instructions sent");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    initial begin : ackResponder
        int delay;
        forever begin
            @(posedge CLK);
            if (retireReq && !retireAck) begin
                delay = {$random(seed)} % 7;
                repeat (delay) @(posedge CLK);
                retireAck <= 1'b1;
                @(posedge CLK);
                while (retireReq) @(posedge CLK);
                retireAck <= 1'b0;
            end
        end
    end

    initial begin : retireChecker
        logic        lastReq;
        retireRecord expectedRec;
        lastReq = 1'b0;
        forever begin
            @(posedge CLK);
            if (retireReq && !lastReq) begin
                if (expectedQ.size() == 0) begin
                    failRun("a record retired with no instruction left to match it");
                end else begin
                    expectedRec = expectedQ.pop_front();
                    checkRecord(expectedRec, retire);
                    retiredCount++;
                end
            end
            lastReq = retireReq;
        end
    end

    initial begin : watchdog
        wait (programReady);
        repeat (resetCycles + cyclesPerInstr * stimulus.size()) @(posedge CLK);
        failRun("run timed out before all records retired");
    end

endmodule

`default_nettype wire

// File: all.f
source/armIsaPkg.sv
source/corePkg.sv
source/instrIntake.sv
source/decodeStage.sv
source/registerFile.sv
source/executeStage.sv
source/retireQueue.sv
source/armCore.sv
tests/armCoreTb.sv
